// ==== led_pkg.sv ====
// LED strip shared definitions

package led_pkg;

    // ============================================================
    // bus and colour widths
    // ============================================================

    localparam int word_w   = 32;  // one word on the LED bus
    localparam int color_w  = 24;  // blue, green, red as stored in the colour RAM
    localparam int bright_w = 5;   // global brightness field

    // ============================================================
    // frame constants
    // ============================================================

    // a frame opens with one word of zeros
    localparam logic [word_w-1:0] start_word = '0;

    // and closes with one word of ones, which pushes the last bits through the chain
    localparam logic [word_w-1:0] end_word = '1;

    // every LED word starts with three set bits
    localparam logic [2:0] led_header = 3'b111;

    // ============================================================
    // frame sequencer states
    // ============================================================

    typedef enum logic [2:0] {
        st_idle,     // waiting for a refresh
        st_start,    // start frame goes to the serializer
        st_read,     // colour read for the current LED
        st_load,     // LED word goes to the serializer
        st_wait_tx,  // serializer still shifting
        st_finish    // end frame goes to the serializer
    } seq_state_e;

endpackage

// ==== led_color_ram.sv ====
// LED colour memory

`timescale 1ns/100ps

module led_color_ram import led_pkg::*; #(
    parameter  int num_leds = 12,
    localparam int addr_w   = (num_leds > 1) ? $clog2(num_leds) : 1
) (
    input  logic               ck,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [addr_w-1:0]  wr_addr,
    input  logic [color_w-1:0] wr_data,
    input  logic               rd_en,
    input  logic [addr_w-1:0]  rd_addr,
    output logic [color_w-1:0] rd_data
);

    logic [color_w-1:0] mem [num_leds];

    always_ff @(posedge ck) begin
        if (wr_en && (wr_addr < num_leds)) begin  // addresses past the last LED are dropped
            mem[wr_addr] <= wr_data;
        end
    end

    // a read in the same cycle as a write to that address returns the old colour
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== led_word_tx.sv ====
// LED bus word serializer

`timescale 1ns/100ps

module led_word_tx import led_pkg::*; #(
    parameter int ck_div = 2
) (
    input  logic              ck,
    input  logic              rst_n,
    input  logic              load,
    input  logic [word_w-1:0] word,
    output logic              led_data,
    output logic              led_ck,
    output logic              tx_busy
);

    localparam int presc_w = (ck_div > 1) ? $clog2(2 * ck_div) : 1;

    // prescale values at the end of the low half and of the whole bit
    localparam logic [presc_w-1:0] low_last = presc_w'(ck_div - 1);
    localparam logic [presc_w-1:0] bit_last = presc_w'(2 * ck_div - 1);

    logic [word_w-1:0]  shift_q;
    logic [presc_w-1:0] presc_q;
    logic [4:0]         bit_cnt_q;

    // the shift register only carries payload and the counters below frame it
    always_ff @(posedge ck) begin
        if (load && !tx_busy) begin
            shift_q <= word;
        end else if (tx_busy && (presc_q == bit_last)) begin
            shift_q <= {shift_q[word_w-2:0], 1'b0};
        end
    end

    // ============================================================
    // bit timing
    // ============================================================

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy   <= 1'b0;
            led_ck    <= 1'b1;  // idle bus clock is high
            led_data  <= 1'b0;
            presc_q   <= '0;
            bit_cnt_q <= '0;
        end else if (!tx_busy) begin
            if (load) begin  // first bit goes out with the falling led_ck
                tx_busy   <= 1'b1;
                led_ck    <= 1'b0;
                led_data  <= word[word_w-1];
                presc_q   <= '0;
                bit_cnt_q <= '0;
            end
        end else if (presc_q == low_last) begin
            led_ck  <= 1'b1;  // LEDs sample here
            presc_q <= presc_q + 1'b1;
        end else if (presc_q == bit_last) begin
            presc_q <= '0;
            if (bit_cnt_q == 5'd31) begin
                // the word is done so the clock stays high and the data line drops back to idle
                tx_busy  <= 1'b0;
                led_data <= 1'b0;
            end else begin
                led_ck    <= 1'b0;
                led_data  <= shift_q[word_w-2];
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

endmodule

// ==== led_frame_seq.sv ====
// LED frame sequencer

`timescale 1ns/100ps

module led_frame_seq import led_pkg::*; #(
    parameter  int num_leds = 12,
    localparam int addr_w   = (num_leds > 1) ? $clog2(num_leds) : 1
) (
    input  logic                ck,
    input  logic                rst_n,
    input  logic                refresh,
    input  logic [bright_w-1:0] brightness,
    output logic                frame_busy,
    output logic                rd_en,
    output logic [addr_w-1:0]   rd_addr,
    input  logic [color_w-1:0]  rd_data,
    output logic                load,
    output logic [word_w-1:0]   word,
    input  logic                tx_busy
);

    // word counter runs past the LEDs so it also marks the end frame
    localparam int cnt_w = $clog2(num_leds + 2);

    localparam logic [cnt_w-1:0] cnt_leds = cnt_w'(num_leds);
    localparam logic [cnt_w-1:0] cnt_end  = cnt_w'(num_leds + 1);

    seq_state_e          state_q;
    logic [cnt_w-1:0]    idx_q;
    logic [bright_w-1:0] bright_q;

    // the RAM samples the read while the FSM sits in st_read, so rd_data is ready in st_load
    assign rd_en   = (state_q == st_read);
    assign rd_addr = idx_q[addr_w-1:0];

    // brightness is held for the whole frame
    always_ff @(posedge ck) begin
        if ((state_q == st_idle) && refresh) begin
            bright_q <= brightness;
        end
    end

    // ============================================================
    // frame FSM
    // ============================================================

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            idx_q      <= '0;
            frame_busy <= 1'b0;
            load       <= 1'b0;
            word       <= '0;
        end else begin
            load <= 1'b0;  // load is a single-cycle strobe

            case (state_q)
                st_idle: begin
                    if (refresh) begin
                        frame_busy <= 1'b1;
                        state_q    <= st_start;
                    end
                end

                st_start: begin
                    load    <= 1'b1;
                    word    <= start_word;
                    idx_q   <= '0;
                    state_q <= st_wait_tx;
                end

                st_read: begin
                    state_q <= st_load;
                end

                st_load: begin
                    load    <= 1'b1;
                    word    <= {led_header, bright_q, rd_data};
                    idx_q   <= idx_q + 1'b1;
                    state_q <= st_wait_tx;
                end

                st_wait_tx: begin
                    // tx_busy only rises the cycle after load, so a pending load means not done
                    if (!load && !tx_busy) begin
                        if (idx_q == cnt_end) begin
                            frame_busy <= 1'b0;
                            state_q    <= st_idle;
                        end else if (idx_q == cnt_leds) begin
                            state_q <= st_finish;
                        end else begin
                            state_q <= st_read;
                        end
                    end
                end

                st_finish: begin
                    load    <= 1'b1;
                    word    <= end_word;
                    idx_q   <= idx_q + 1'b1;  // now equals cnt_end
                    state_q <= st_wait_tx;
                end

                default: begin
                    frame_busy <= 1'b0;
                    state_q    <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== led_strip_top.sv ====
// LED strip driver top level

`timescale 1ns/100ps

module led_strip_top import led_pkg::*; #(
    parameter  int num_leds = 12,
    parameter  int ck_div   = 2,
    localparam int addr_w   = (num_leds > 1) ? $clog2(num_leds) : 1
) (
    input  logic                ck,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [addr_w-1:0]   wr_addr,
    input  logic [color_w-1:0]  wr_data,
    input  logic                refresh,
    input  logic [bright_w-1:0] brightness,
    output logic                frame_busy,
    output logic                led_data,
    output logic                led_ck
);

    logic               rd_en;
    logic [addr_w-1:0]  rd_addr;
    logic [color_w-1:0] rd_data;
    logic               load;
    logic [word_w-1:0]  word;
    logic               tx_busy;

    // ============================================================
    // colour store, sequencer and serializer
    // ============================================================

    led_color_ram #(.num_leds(num_leds)) i_ram (
        .ck      (ck),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    led_frame_seq #(.num_leds(num_leds)) i_seq (
        .ck         (ck),
        .rst_n      (rst_n),
        .refresh    (refresh),
        .brightness (brightness),
        .frame_busy (frame_busy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .load       (load),
        .word       (word),
        .tx_busy    (tx_busy)
    );

    led_word_tx #(.ck_div(ck_div)) i_tx (
        .ck       (ck),
        .rst_n    (rst_n),
        .load     (load),
        .word     (word),
        .led_data (led_data),
        .led_ck   (led_ck),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== led_strip_checker.sv ====
// LED bus frame checker

`timescale 1ns/100ps

module led_strip_checker import led_pkg::*; #(
    parameter int num_leds = 12,
    parameter int ck_div   = 2
) (
    input  logic                                 ck,
    input  logic                                 rst_n,
    input  logic                                 led_ck,
    input  logic                                 led_data,
    input  logic                                 frame_busy,
    input  logic                                 exp_push,
    input  logic [(num_leds+2)*word_w-1:0]       exp_frame,
    output int                                   err_cnt,
    output int                                   frame_cnt
);

    localparam int words_per_frame = num_leds + 2;
    localparam int frame_w         = words_per_frame * word_w;

    logic [frame_w-1:0] exp_q [$];  // expected frames, oldest first
    logic [frame_w-1:0] cur_frame;
    logic [word_w-1:0]  shift;
    logic [word_w-1:0]  exp_word;
    logic               led_ck_q;
    logic               busy_q;
    logic               in_frame;
    logic               bit_val;
    int                 bit_cnt;
    int                 word_cnt;
    int                 hi_cnt;
    int                 lo_cnt;

    // name of the check that covers a given word of the frame
    function automatic string word_test(input int idx);
        if (idx == 0) begin
            return "start_word";
        end else if (idx == num_leds + 1) begin
            return "end_word";
        end
        return $sformatf("led_word_%0d", idx - 1);
    endfunction

    always @(posedge ck) begin
        if (!rst_n) begin
            led_ck_q  = 1'b1;
            busy_q    = 1'b0;
            in_frame  = 1'b0;
            bit_val   = 1'b0;
            bit_cnt   = 0;
            word_cnt  = 0;
            hi_cnt    = ck_div;
            lo_cnt    = 0;
            err_cnt   = 0;
            frame_cnt = 0;
        end else begin
            if (exp_push) begin
                exp_q.push_back(exp_frame);
                if (!frame_busy) begin  // frame_busy follows an accepted refresh by one cycle
                    $display("error: frame_busy low one cycle after an accepted refresh");
                    err_cnt++;
                end
            end

            // ============================================================
            // frame start and idle bus
            // ============================================================

            if (frame_busy && !busy_q) begin
                bit_cnt  = 0;
                word_cnt = 0;
                in_frame = (exp_q.size() != 0);
                if (in_frame) begin
                    cur_frame = exp_q.pop_front();
                end else begin
                    $display("error: frame %0d started without an accepted refresh", frame_cnt);
                    err_cnt++;
                end
            end

            if (!frame_busy && ((led_ck !== 1'b1) || (led_data !== 1'b0))) begin
                $display("error: idle_bus expected led_ck 1 led_data 0 actual led_ck %b led_data %b",
                         led_ck, led_data);
                err_cnt++;
            end

            // ============================================================
            // bit decoding and bit timing
            // ============================================================

            if (led_ck && !led_ck_q) begin
                if (lo_cnt != ck_div) begin
                    $display("error: bit_timing low phase expected %0d actual %0d", ck_div, lo_cnt);
                    err_cnt++;
                end
                lo_cnt  = 0;
                hi_cnt  = 1;
                bit_val = led_data;  // LEDs sample on the rising led_ck
                if (!frame_busy) begin
                    $display("error: led_ck rose outside a frame");
                    err_cnt++;
                end else begin
                    shift = {shift[word_w-2:0], led_data};
                    bit_cnt++;
                end
                if (bit_cnt == word_w) begin
                    if (word_cnt >= words_per_frame) begin
                        $display("error: frame %0d carries extra bits after the end word",
                                 frame_cnt);
                        err_cnt++;
                    end else if (in_frame) begin
                        exp_word = cur_frame[(words_per_frame-1-word_cnt)*word_w +: word_w];
                        if (shift !== exp_word) begin
                            $display("error: %s frame %0d expected %h actual %h",
                                     word_test(word_cnt), frame_cnt, exp_word, shift);
                            err_cnt++;
                        end
                    end
                    word_cnt++;
                    bit_cnt = 0;
                end
            end else if (led_ck) begin
                if ((hi_cnt < ck_div) && (led_data !== bit_val)) begin
                    $display("error: bit_timing led_data expected %b actual %b during high led_ck",
                             bit_val, led_data);
                    err_cnt++;
                end
                hi_cnt++;
            end else begin
                // the last bit of a word runs into idle so its high phase is not fixed
                if (led_ck_q && (bit_cnt != 0) && (hi_cnt != ck_div)) begin
                    $display("error: bit_timing high phase expected %0d actual %0d",
                             ck_div, hi_cnt);
                    err_cnt++;
                end
                lo_cnt++;
            end

            // frame end
            if (!frame_busy && busy_q) begin
                if (bit_cnt != 0) begin
                    $display("error: frame %0d ended inside a word after %0d bits",
                             frame_cnt, bit_cnt);
                    err_cnt++;
                end
                if (word_cnt != words_per_frame) begin
                    $display("error: frame %0d carried %0d words instead of %0d",
                             frame_cnt, word_cnt, words_per_frame);
                    err_cnt++;
                end
                frame_cnt++;
            end

            led_ck_q = led_ck;
            busy_q   = frame_busy;
        end
    end

endmodule

// ==== tb_led_strip.sv ====
// LED strip testbench

`timescale 1ns/100ps

module tb_led_strip import led_pkg::*; #(
    parameter int num_leds = 12,
    parameter int ck_div   = 2
);

    localparam int addr_w          = (num_leds > 1) ? $clog2(num_leds) : 1;
    localparam int num_frames      = 16;
    localparam int words_per_frame = num_leds + 2;
    localparam int frame_w         = words_per_frame * word_w;
    localparam int watchdog_cycles = (num_frames + 2) * words_per_frame * word_w * 2 * ck_div * 3;
    localparam int rand_seed       = 48;

    logic                ck;
    logic                rst_n;
    logic                wr_en;
    logic [addr_w-1:0]   wr_addr;
    logic [color_w-1:0]  wr_data;
    logic                refresh;
    logic [bright_w-1:0] brightness;
    logic                frame_busy;
    logic                led_data;
    logic                led_ck;

    logic                exp_push;
    logic [frame_w-1:0]  exp_frame;
    logic [color_w-1:0]  shadow [num_leds];  // colours as the host last wrote them
    int                  acc_cnt;
    int                  tb_errors;
    int                  chk_errors;
    int                  frames_seen;

    led_strip_top #(.num_leds(num_leds), .ck_div(ck_div)) i_dut (
        .ck         (ck),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .refresh    (refresh),
        .brightness (brightness),
        .frame_busy (frame_busy),
        .led_data   (led_data),
        .led_ck     (led_ck)
    );

    led_strip_checker #(.num_leds(num_leds), .ck_div(ck_div)) i_checker (
        .ck         (ck),
        .rst_n      (rst_n),
        .led_ck     (led_ck),
        .led_data   (led_data),
        .frame_busy (frame_busy),
        .exp_push   (exp_push),
        .exp_frame  (exp_frame),
        .err_cnt    (chk_errors),
        .frame_cnt  (frames_seen)
    );

    initial begin
        ck = 1'b0;
        forever #10 ck = ~ck;
    end

    // ============================================================
    // colour model
    // ============================================================

    function automatic logic [frame_w-1:0] build_frame(input logic [bright_w-1:0] br);
        logic [frame_w-1:0] f;
        f = '0;
        f[frame_w-1 -: word_w] = start_word;
        for (int i = 0; i < num_leds; i++) begin
            f[(num_leds-i)*word_w +: word_w] = {led_header, br, shadow[i]};
        end
        f[word_w-1:0] = end_word;
        return f;
    endfunction

    // the DUT takes a refresh only while no frame runs
    always @(posedge ck) begin
        exp_push <= 1'b0;
        if (rst_n) begin
            if (wr_en) begin
                shadow[wr_addr] = wr_data;
            end
            if (refresh && !frame_busy) begin
                exp_frame <= build_frame(brightness);
                exp_push  <= 1'b1;
                acc_cnt++;
            end
        end
    end

    // ============================================================
    // stimulus
    // ============================================================

    task automatic write_colour(input int addr, input logic [color_w-1:0] data);
        @(posedge ck);
        wr_en   <= 1'b1;
        wr_addr <= addr[addr_w-1:0];
        wr_data <= data;
        @(posedge ck);
        wr_en   <= 1'b0;
    endtask

    task automatic run_frame();
        int n_writes;
        int delay;
        n_writes = $urandom_range(0, 6);
        repeat (n_writes) write_colour($urandom_range(0, num_leds - 1), color_w'($urandom));
        @(posedge ck);
        refresh    <= 1'b1;
        brightness <= bright_w'($urandom);
        @(posedge ck);
        refresh    <= 1'b0;
        brightness <= bright_w'($urandom);  // input moves on while the frame runs
        @(posedge ck);
        if ($urandom_range(0, 2) == 0) begin
            // well inside the shortest frame, so this one must be dropped
            delay = $urandom_range(1, 500);
            repeat (delay) @(posedge ck);
            refresh    <= 1'b1;
            brightness <= bright_w'($urandom);
            @(posedge ck);
            refresh    <= 1'b0;
        end
        while (frame_busy) @(posedge ck);
    endtask

    initial begin
        void'($urandom(rand_seed));
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        refresh    = 1'b0;
        brightness = '0;
        exp_push   = 1'b0;
        exp_frame  = '0;
        acc_cnt    = 0;
        tb_errors  = 0;
        repeat (3) @(posedge ck);
        rst_n <= 1'b1;

        for (int a = 0; a < num_leds; a++) begin
            write_colour(a, color_w'($urandom));
        end
        repeat (num_frames) run_frame();
        repeat (20) @(posedge ck);

        if ((frames_seen != acc_cnt) || (frames_seen != num_frames)) begin
            $display("error: %0d frames decoded but %0d refreshes accepted and %0d sent at idle",
                     frames_seen, acc_cnt, num_frames);
            tb_errors++;
        end

        $display("errors: %0d checker, %0d testbench; frames: %0d decoded, %0d accepted",
                 chk_errors, tb_errors, frames_seen, acc_cnt);
        if ((chk_errors == 0) && (tb_errors == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge ck);
        $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
led_pkg.sv
led_color_ram.sv
led_word_tx.sv
led_frame_seq.sv
led_strip_top.sv
led_strip_checker.sv
tb_led_strip.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LED strip testbench with Verilator, then judge the log

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_led_strip -f sources.f \
    && ./obj_dir/Vtb_led_strip > sim.log 2>&1 \
    || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "^Result: PASSED$" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
